// File: design/corevx_cache_pkg.sv
package corevx_cache_pkg;

    // address geometry, Sv32 style with 4 KiB pages
    localparam int VADDR_W       = 32;
    localparam int PADDR_W       = 32;
    localparam int PAGE_OFFSET_W = 12;
    localparam int VPN_W         = VADDR_W - PAGE_OFFSET_W;
    localparam int PPN_W         = PADDR_W - PAGE_OFFSET_W;

    localparam int TLB_ENTRIES = 4;
    localparam int TLB_IDX_W   = $clog2(TLB_ENTRIES);

    // accesstag layout, one bit per PTE flag
    localparam int ACCESSTAG_W           = 8;
    localparam int ACCESSTAG_VALID_BIT   = 0;
    localparam int ACCESSTAG_READ_BIT    = 1;
    localparam int ACCESSTAG_WRITE_BIT   = 2;
    localparam int ACCESSTAG_EXECUTE_BIT = 3;
    localparam int ACCESSTAG_USER_BIT    = 4;
    localparam int ACCESSTAG_GLOBAL_BIT  = 5;
    localparam int ACCESSTAG_ACCESS_BIT  = 6;
    localparam int ACCESSTAG_DIRTY_BIT   = 7;

    // csr write data and the status field positions inside it
    localparam int CSR_DATA_W      = 8;
    localparam int STATUS_SUM_BIT  = 0;
    localparam int STATUS_MXR_BIT  = 1;
    localparam int STATUS_MPRV_BIT = 2;
    localparam int STATUS_MPP_LSB  = 3;

    typedef enum logic [3:0] {
        CMD_NONE    = 4'd0,
        CMD_LOAD    = 4'd1,
        CMD_STORE   = 4'd2,
        CMD_EXECUTE = 4'd3
    } cache_cmd_e;

    typedef enum logic [1:0] {
        PRIV_USER       = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_MACHINE    = 2'd3
    } privilege_e;

    typedef enum logic [1:0] {
        CSR_SATP      = 2'd0,
        CSR_STATUS    = 2'd1,
        CSR_PRIVILEGE = 2'd2
    } csr_sel_e;

    // nine reasons, so the field is four bits wide
    typedef enum logic [3:0] {
        REASON_NONE,
        REASON_INVALID,
        REASON_SUPERVISOR_USER_PAGE,
        REASON_USER_NOT_USER_PAGE,
        REASON_ACCESS_CLEAR,
        REASON_DIRTY_CLEAR,
        REASON_STORE_UNWRITABLE,
        REASON_LOAD_UNREADABLE,
        REASON_EXECUTE_NOT_EXECUTABLE
    } fault_reason_e;

endpackage

// File: design/corevx_cache_csr.sv
`timescale 1ns/1ps

module corevx_cache_csr import corevx_cache_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  csr_we,
    input  csr_sel_e              csr_sel,
    input  logic [CSR_DATA_W-1:0] csr_wdata,
    output logic                  translate_en,
    output privilege_e            eff_privilege,
    output logic                  status_sum,
    output logic                  status_mxr
);

    logic       satp_mode;
    privilege_e cur_privilege;
    logic       status_mprv;
    privilege_e status_mpp;

    // writes land at the sampling edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            satp_mode     <= 1'b0;
            cur_privilege <= PRIV_MACHINE;
            status_sum    <= 1'b0;
            status_mxr    <= 1'b0;
            status_mprv   <= 1'b0;
            status_mpp    <= PRIV_USER;
        end else if (csr_we) begin
            case (csr_sel)
                CSR_SATP: begin
                    satp_mode <= csr_wdata[0];
                end
                CSR_STATUS: begin
                    status_sum  <= csr_wdata[STATUS_SUM_BIT];
                    status_mxr  <= csr_wdata[STATUS_MXR_BIT];
                    status_mprv <= csr_wdata[STATUS_MPRV_BIT];
                    status_mpp  <= privilege_e'(csr_wdata[STATUS_MPP_LSB +: 2]);
                end
                CSR_PRIVILEGE: begin
                    cur_privilege <= privilege_e'(csr_wdata[1:0]);
                end
                default: begin
                end
            endcase
        end
    end

    // machine mode with mprv set borrows mpp for loads and stores
    always_comb begin
        if (cur_privilege == PRIV_MACHINE && status_mprv) begin
            eff_privilege = status_mpp;
        end else begin
            eff_privilege = cur_privilege;
        end
    end

    // machine accesses are always physical
    assign translate_en = satp_mode && (eff_privilege != PRIV_MACHINE);

endmodule

// File: design/corevx_cache_tlb.sv
`timescale 1ns/1ps

module corevx_cache_tlb import corevx_cache_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,
    input  logic                   fill_valid,
    input  logic [VPN_W-1:0]       fill_vpn,
    input  logic [PPN_W-1:0]       fill_ppn,
    input  logic [ACCESSTAG_W-1:0] fill_accesstag,
    input  logic                   req_valid,
    input  cache_cmd_e             req_cmd,
    input  logic [VADDR_W-1:0]     req_vaddr,
    input  logic                   translate_en,
    input  privilege_e             eff_privilege,
    output logic                   lookup_valid,
    output logic                   lookup_hit,
    output cache_cmd_e             lookup_cmd,
    output logic [ACCESSTAG_W-1:0] lookup_accesstag,
    output logic [PADDR_W-1:0]     resp_paddr
);

    logic [TLB_ENTRIES-1:0] entry_valid;
    logic [VPN_W-1:0]       entry_vpn [TLB_ENTRIES];
    logic [PPN_W-1:0]       entry_ppn [TLB_ENTRIES];
    logic [ACCESSTAG_W-1:0] entry_tag [TLB_ENTRIES];
    logic [TLB_IDX_W-1:0]   victim;

    logic [VPN_W-1:0]       req_vpn;
    logic                   match_any;
    logic [PPN_W-1:0]       match_ppn;
    logic [ACCESSTAG_W-1:0] match_tag;
    logic [ACCESSTAG_W-1:0] bypass_tag;

    logic                   xlate_q;
    logic                   hit_q;
    logic [PPN_W-1:0]       ppn_q;
    logic [VADDR_W-1:0]     vaddr_q;

    // valid bits and round-robin victim, flush has priority over fill
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_valid <= '0;
            victim      <= '0;
        end else if (flush) begin
            entry_valid <= '0;
        end else if (fill_valid) begin
            entry_valid[victim] <= 1'b1;
            victim              <= victim + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid && !flush) begin
            entry_vpn[victim] <= fill_vpn;
            entry_ppn[victim] <= fill_ppn;
            entry_tag[victim] <= fill_accesstag;
        end
    end

    assign req_vpn = req_vaddr[VADDR_W-1:PAGE_OFFSET_W];

    // parallel compare, lowest index wins on a duplicate vpn
    always_comb begin
        match_any = 1'b0;
        match_ppn = '0;
        match_tag = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entry_valid[i] && entry_vpn[i] == req_vpn) begin
                match_any = 1'b1;
                match_ppn = entry_ppn[i];
                match_tag = entry_tag[i];
            end
        end
    end

    // physical access gets a tag that passes every check
    // U follows the privilege so neither user rule fires
    always_comb begin
        bypass_tag                        = '0;
        bypass_tag[ACCESSTAG_VALID_BIT]   = 1'b1;
        bypass_tag[ACCESSTAG_READ_BIT]    = 1'b1;
        bypass_tag[ACCESSTAG_WRITE_BIT]   = 1'b1;
        bypass_tag[ACCESSTAG_EXECUTE_BIT] = 1'b1;
        bypass_tag[ACCESSTAG_GLOBAL_BIT]  = 1'b1;
        bypass_tag[ACCESSTAG_ACCESS_BIT]  = 1'b1;
        bypass_tag[ACCESSTAG_DIRTY_BIT]   = 1'b1;
        bypass_tag[ACCESSTAG_USER_BIT]    = (eff_privilege == PRIV_USER);
    end

    // the single lookup stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lookup_valid <= 1'b0;
            xlate_q      <= 1'b0;
            hit_q        <= 1'b0;
        end else begin
            lookup_valid <= req_valid;
            if (req_valid) begin
                xlate_q <= translate_en;
                hit_q   <= match_any;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            lookup_cmd       <= req_cmd;
            lookup_accesstag <= translate_en ? match_tag : bypass_tag;
            ppn_q            <= match_ppn;
            vaddr_q          <= req_vaddr;
        end
    end

    assign lookup_hit = !xlate_q || hit_q;

    // a miss returns zero
    always_comb begin
        if (!xlate_q) begin
            resp_paddr = vaddr_q;
        end else if (hit_q) begin
            resp_paddr = {ppn_q, vaddr_q[PAGE_OFFSET_W-1:0]};
        end else begin
            resp_paddr = '0;
        end
    end

endmodule

// File: design/corevx_cache_pagefault.sv
`timescale 1ns/1ps

module corevx_cache_pagefault import corevx_cache_pkg::*; (
    input  logic                   lookup_valid,
    input  logic                   lookup_hit,
    input  cache_cmd_e             lookup_cmd,
    input  logic [ACCESSTAG_W-1:0] lookup_accesstag,
    input  privilege_e             eff_privilege,
    input  logic                   status_sum,
    input  logic                   status_mxr,
    output logic                   pagefault,
    output fault_reason_e          reason
);

    logic tag_readable;
    logic tag_writable;
    logic tag_executable;
    logic tag_user;
    logic tag_access;
    logic tag_dirty;
    logic tag_ok;

    assign tag_readable   = lookup_accesstag[ACCESSTAG_READ_BIT];
    assign tag_writable   = lookup_accesstag[ACCESSTAG_WRITE_BIT];
    assign tag_executable = lookup_accesstag[ACCESSTAG_EXECUTE_BIT];
    assign tag_user       = lookup_accesstag[ACCESSTAG_USER_BIT];
    assign tag_access     = lookup_accesstag[ACCESSTAG_ACCESS_BIT];
    assign tag_dirty      = lookup_accesstag[ACCESSTAG_DIRTY_BIT];

    // a leaf needs V and at least one of R or X
    assign tag_ok = lookup_accesstag[ACCESSTAG_VALID_BIT] && (tag_readable || tag_executable);

    // checks run in order and a later one overwrites the reason
    always_comb begin
        pagefault = 1'b0;
        reason    = REASON_NONE;
        if (lookup_valid && lookup_hit) begin
            if (!tag_ok) begin
                pagefault = 1'b1;
                reason    = REASON_INVALID;
            end

            if (eff_privilege == PRIV_SUPERVISOR) begin
                if (tag_user && !status_sum) begin
                    pagefault = 1'b1;
                    reason    = REASON_SUPERVISOR_USER_PAGE;
                end
            end else if (eff_privilege == PRIV_USER) begin
                if (!tag_user) begin
                    pagefault = 1'b1;
                    reason    = REASON_USER_NOT_USER_PAGE;
                end
            end

            // A clear masks all command checks
            if (!tag_access) begin
                pagefault = 1'b1;
                reason    = REASON_ACCESS_CLEAR;
            end else begin
                case (lookup_cmd)
                    CMD_STORE: begin
                        // dirty is checked before write permission
                        if (!tag_dirty) begin
                            pagefault = 1'b1;
                            reason    = REASON_DIRTY_CLEAR;
                        end else if (!tag_writable) begin
                            pagefault = 1'b1;
                            reason    = REASON_STORE_UNWRITABLE;
                        end
                    end
                    CMD_LOAD: begin
                        // mxr makes executable pages readable
                        if (!tag_readable && !(status_mxr && tag_executable)) begin
                            pagefault = 1'b1;
                            reason    = REASON_LOAD_UNREADABLE;
                        end
                    end
                    CMD_EXECUTE: begin
                        if (!tag_executable) begin
                            pagefault = 1'b1;
                            reason    = REASON_EXECUTE_NOT_EXECUTABLE;
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

// File: design/corevx_cache_mmu.sv
`timescale 1ns/1ps

module corevx_cache_mmu import corevx_cache_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    // csr write strobe
    input  logic                   csr_we,
    input  csr_sel_e               csr_sel,
    input  logic [CSR_DATA_W-1:0]  csr_wdata,
    // tlb fill and flush
    input  logic                   fill_valid,
    input  logic [VPN_W-1:0]       fill_vpn,
    input  logic [PPN_W-1:0]       fill_ppn,
    input  logic [ACCESSTAG_W-1:0] fill_accesstag,
    input  logic                   flush,
    // request
    input  logic                   req_valid,
    input  cache_cmd_e             req_cmd,
    input  logic [VADDR_W-1:0]     req_vaddr,
    // response, one cycle after the request
    output logic                   resp_valid,
    output logic [PADDR_W-1:0]     resp_paddr,
    output logic                   resp_miss,
    output logic                   resp_pagefault,
    output fault_reason_e          resp_reason
);

    logic                   translate_en;
    privilege_e             eff_privilege;
    logic                   status_sum;
    logic                   status_mxr;

    logic                   lookup_valid;
    logic                   lookup_hit;
    cache_cmd_e             lookup_cmd;
    logic [ACCESSTAG_W-1:0] lookup_accesstag;

    corevx_cache_csr u_csr (
        .clk           (clk),
        .rst_n         (rst_n),
        .csr_we        (csr_we),
        .csr_sel       (csr_sel),
        .csr_wdata     (csr_wdata),
        .translate_en  (translate_en),
        .eff_privilege (eff_privilege),
        .status_sum    (status_sum),
        .status_mxr    (status_mxr)
    );

    corevx_cache_tlb u_tlb (
        .clk              (clk),
        .rst_n            (rst_n),
        .flush            (flush),
        .fill_valid       (fill_valid),
        .fill_vpn         (fill_vpn),
        .fill_ppn         (fill_ppn),
        .fill_accesstag   (fill_accesstag),
        .req_valid        (req_valid),
        .req_cmd          (req_cmd),
        .req_vaddr        (req_vaddr),
        .translate_en     (translate_en),
        .eff_privilege    (eff_privilege),
        .lookup_valid     (lookup_valid),
        .lookup_hit       (lookup_hit),
        .lookup_cmd       (lookup_cmd),
        .lookup_accesstag (lookup_accesstag),
        .resp_paddr       (resp_paddr)
    );

    corevx_cache_pagefault u_pagefault (
        .lookup_valid     (lookup_valid),
        .lookup_hit       (lookup_hit),
        .lookup_cmd       (lookup_cmd),
        .lookup_accesstag (lookup_accesstag),
        .eff_privilege    (eff_privilege),
        .status_sum       (status_sum),
        .status_mxr       (status_mxr),
        .pagefault        (resp_pagefault),
        .reason           (resp_reason)
    );

    assign resp_valid = lookup_valid;
    assign resp_miss  = lookup_valid && !lookup_hit;

endmodule

// File: test/corevx_cache_mmu_assertions.sv
`timescale 1ns/1ps

module corevx_cache_mmu_assertions (
    input logic clk,
    input logic rst_n,
    input logic req_valid,
    input logic resp_valid,
    input logic resp_miss,
    input logic resp_pagefault
);

    // one flag per rule, each written by its own action block
    logic follow_failed = 1'b0;
    logic qualify_failed = 1'b0;
    logic miss_fault_failed = 1'b0;
    logic reset_failed = 1'b0;
    logic any_failed;

    assign any_failed = follow_failed || qualify_failed || miss_fault_failed || reset_failed;

    // exactly one response per request, in the following cycle
    a_resp_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid |=> resp_valid) and (!req_valid |=> !resp_valid))
        else begin
            follow_failed = 1'b1;
            $error("resp_valid does not follow req_valid by one cycle");
        end

    a_flags_need_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (resp_miss || resp_pagefault) |-> resp_valid)
        else begin
            qualify_failed = 1'b1;
            $error("resp_miss or resp_pagefault high without resp_valid");
        end

    a_miss_no_fault: assert property (@(posedge clk) disable iff (!rst_n)
        resp_miss |-> !resp_pagefault)
        else begin
            miss_fault_failed = 1'b1;
            $error("a tlb miss also reports a page fault");
        end

    a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !resp_valid)
        else begin
            reset_failed = 1'b1;
            $error("resp_valid high while reset is asserted");
        end

endmodule

// File: test/tb_corevx_cache_mmu.sv
`timescale 1ns/1ps

module tb_corevx_cache_mmu import corevx_cache_pkg::*; ();

    localparam int RESP_TIMEOUT = 20;

    logic                   clk = 1'b1;
    logic                   rst_n = 1'b1;
    logic                   csr_we;
    csr_sel_e               csr_sel;
    logic [CSR_DATA_W-1:0]  csr_wdata;
    logic                   fill_valid;
    logic [VPN_W-1:0]       fill_vpn;
    logic [PPN_W-1:0]       fill_ppn;
    logic [ACCESSTAG_W-1:0] fill_accesstag;
    logic                   flush;
    logic                   req_valid;
    cache_cmd_e             req_cmd;
    logic [VADDR_W-1:0]     req_vaddr;
    logic                   resp_valid;
    logic [PADDR_W-1:0]     resp_paddr;
    logic                   resp_miss;
    logic                   resp_pagefault;
    fault_reason_e          resp_reason;

    // csr state as the testbench has written it
    logic       m_satp;
    privilege_e m_priv;
    logic       m_mprv;
    privilege_e m_mpp;
    logic       m_sum;
    logic       m_mxr;

    logic [31:0] lcg_state = 32'd32;
    cache_cmd_e  cmds [3] = '{CMD_LOAD, CMD_STORE, CMD_EXECUTE};

    // expectations for the streamed requests
    cache_cmd_e       s_cmd   [5];
    logic [31:0]      s_vaddr [5];
    logic             s_hit   [5];
    logic [PPN_W-1:0] s_ppn   [5];
    logic [7:0]       s_tag   [5];

    corevx_cache_mmu u_dut (.*);

    bind corevx_cache_mmu corevx_cache_mmu_assertions u_assertions (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .resp_valid     (resp_valid),
        .resp_miss      (resp_miss),
        .resp_pagefault (resp_pagefault)
    );

    // first edge is a falling one, so reset is applied before any rising edge
    initial begin
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    always @(negedge clk) begin
        if (u_dut.u_assertions.any_failed) begin
            abort_run("a bound assertion on the response protocol failed");
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic privilege_e effective_privilege();
        if (m_priv == PRIV_MACHINE && m_mprv) begin
            return m_mpp;
        end
        return m_priv;
    endfunction

    function automatic logic translation_on();
        return m_satp && (effective_privilege() != PRIV_MACHINE);
    endfunction

    // fault rule, each later check overrides an earlier one
    task automatic apply_fault_rule(input logic [7:0] tag, input cache_cmd_e cmd,
                                    input privilege_e priv, output logic fault,
                                    output fault_reason_e why);
        fault = 1'b0;
        why = REASON_NONE;
        if (!(tag[0] && (tag[1] || tag[3]))) begin
            fault = 1'b1;
            why = REASON_INVALID;
        end
        if (priv == PRIV_SUPERVISOR && tag[4] && !m_sum) begin
            fault = 1'b1;
            why = REASON_SUPERVISOR_USER_PAGE;
        end
        if (priv == PRIV_USER && !tag[4]) begin
            fault = 1'b1;
            why = REASON_USER_NOT_USER_PAGE;
        end
        if (!tag[6]) begin
            fault = 1'b1;
            why = REASON_ACCESS_CLEAR;
        end else if (cmd == CMD_STORE && !tag[7]) begin
            fault = 1'b1;
            why = REASON_DIRTY_CLEAR;
        end else if (cmd == CMD_STORE && !tag[2]) begin
            fault = 1'b1;
            why = REASON_STORE_UNWRITABLE;
        end else if (cmd == CMD_LOAD && !tag[1] && !(m_mxr && tag[3])) begin
            fault = 1'b1;
            why = REASON_LOAD_UNREADABLE;
        end else if (cmd == CMD_EXECUTE && !tag[3]) begin
            fault = 1'b1;
            why = REASON_EXECUTE_NOT_EXECUTABLE;
        end
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("error %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compare_response(input cache_cmd_e cmd, input logic [31:0] vaddr,
                                    input logic hit, input logic [PPN_W-1:0] ppn,
                                    input logic [7:0] tag);
        logic [31:0]   exp_paddr;
        logic          exp_miss;
        logic          exp_fault;
        fault_reason_e exp_reason;
        exp_miss = 1'b0;
        exp_fault = 1'b0;
        exp_reason = REASON_NONE;
        if (!translation_on()) begin
            exp_paddr = vaddr;
        end else if (!hit) begin
            exp_paddr = '0;
            exp_miss = 1'b1;
        end else begin
            exp_paddr = {ppn, vaddr[PAGE_OFFSET_W-1:0]};
            apply_fault_rule(tag, cmd, effective_privilege(), exp_fault, exp_reason);
        end
        expect_equal("resp_paddr", resp_paddr, exp_paddr);
        expect_equal("resp_miss", 32'(resp_miss), 32'(exp_miss));
        expect_equal("resp_pagefault", 32'(resp_pagefault), 32'(exp_fault));
        expect_equal("resp_reason", 32'(resp_reason), 32'(exp_reason));
    endtask

    task automatic request_and_check(input cache_cmd_e cmd, input logic [31:0] vaddr,
                                     input logic hit, input logic [PPN_W-1:0] ppn,
                                     input logic [7:0] tag);
        int waited;
        @(negedge clk);
        req_valid = 1'b1;
        req_cmd = cmd;
        req_vaddr = vaddr;
        @(negedge clk);
        req_valid = 1'b0;
        waited = 0;
        while (!resp_valid && waited < RESP_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        assert (resp_valid) else abort_run("timeout waiting for resp_valid after a request");
        compare_response(cmd, vaddr, hit, ppn, tag);
    endtask

    task automatic write_csr(input csr_sel_e sel, input logic [7:0] data);
        @(negedge clk);
        csr_we = 1'b1;
        csr_sel = sel;
        csr_wdata = data;
        @(negedge clk);
        csr_we = 1'b0;
        case (sel)
            CSR_SATP: m_satp = data[0];
            CSR_STATUS: begin
                m_sum = data[0];
                m_mxr = data[1];
                m_mprv = data[2];
                m_mpp = privilege_e'(data[4:3]);
            end
            default: m_priv = privilege_e'(data[1:0]);
        endcase
    endtask

    task automatic fill_entry(input logic [VPN_W-1:0] vpn, input logic [PPN_W-1:0] ppn,
                              input logic [7:0] tag);
        @(negedge clk);
        fill_valid = 1'b1;
        fill_vpn = vpn;
        fill_ppn = ppn;
        fill_accesstag = tag;
        @(negedge clk);
        fill_valid = 1'b0;
    endtask

    task automatic flush_tlb();
        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
    endtask

    task automatic set_stream(input int i, input cache_cmd_e cmd, input logic [31:0] vaddr,
                              input logic hit, input logic [PPN_W-1:0] ppn,
                              input logic [7:0] tag);
        s_cmd[i] = cmd;
        s_vaddr[i] = vaddr;
        s_hit[i] = hit;
        s_ppn[i] = ppn;
        s_tag[i] = tag;
    endtask

    initial begin
        int          cfg;
        int          k;
        int          c;
        int          i;
        logic [31:0] rnd;
        logic [31:0] rnd_ofs;
        logic [7:0]  tag;
        logic [19:0] vpn;
        logic        mprv;
        privilege_e  priv;
        privilege_e  mpp;
        csr_we = 1'b0;
        csr_sel = CSR_SATP;
        csr_wdata = '0;
        fill_valid = 1'b0;
        fill_vpn = '0;
        fill_ppn = '0;
        fill_accesstag = '0;
        flush = 1'b0;
        req_valid = 1'b0;
        req_cmd = CMD_NONE;
        req_vaddr = '0;
        m_satp = 1'b0;
        m_priv = PRIV_MACHINE;
        m_mprv = 1'b0;
        m_mpp = PRIV_USER;
        m_sum = 1'b0;
        m_mxr = 1'b0;
        @(negedge clk);
        rst_n = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // bypass with an empty tlb
        request_and_check(CMD_LOAD, 32'h1234_5678, 1'b0, '0, '0);
        write_csr(CSR_PRIVILEGE, 8'(PRIV_USER));
        request_and_check(CMD_STORE, 32'h8765_4321, 1'b0, '0, '0);
        write_csr(CSR_SATP, 8'h01);
        write_csr(CSR_PRIVILEGE, 8'(PRIV_MACHINE));
        request_and_check(CMD_EXECUTE, 32'hdead_beef, 1'b0, '0, '0);

        // translation on, fill, hit, miss, flush and eviction
        write_csr(CSR_STATUS, 8'h00);
        write_csr(CSR_PRIVILEGE, 8'(PRIV_SUPERVISOR));
        fill_entry(20'h10000, 20'habcde, 8'hcf);
        request_and_check(CMD_LOAD, 32'h1000_0123, 1'b1, 20'habcde, 8'hcf);
        request_and_check(CMD_LOAD, 32'h2000_0123, 1'b0, '0, '0);
        flush_tlb();
        request_and_check(CMD_LOAD, 32'h1000_0123, 1'b0, '0, '0);
        for (k = 0; k < 5; k++) begin
            fill_entry(20'h30000 + k, 20'h70000 + k, 8'hcf);
        end
        request_and_check(CMD_LOAD, 32'h3000_0004, 1'b0, '0, '0);
        for (k = 1; k < 5; k++) begin
            request_and_check(CMD_LOAD, {20'(20'h30000 + k), 12'h004}, 1'b1,
                              20'h70000 + k, 8'hcf);
        end

        // random tags over every privilege setup, sum and mxr
        for (cfg = 0; cfg < 16; cfg++) begin
            mprv = cfg[1];
            priv = mprv ? PRIV_MACHINE : privilege_e'(cfg[0]);
            mpp = privilege_e'(cfg[0]);
            write_csr(CSR_STATUS, {3'b000, mpp, mprv, cfg[3], cfg[2]});
            write_csr(CSR_PRIVILEGE, 8'(priv));
            for (k = 0; k < 4; k++) begin
                rnd = next_random();
                tag = rnd[7:0] | (rnd[8] ? 8'h41 : 8'h00);
                vpn = 20'h50000 + 20'(cfg * 4 + k);
                fill_entry(vpn, rnd[31:12], tag);
                for (c = 0; c < 3; c++) begin
                    rnd_ofs = next_random();
                    request_and_check(cmds[c], {vpn, rnd_ofs[11:0]}, 1'b1,
                                      rnd[31:12], tag);
                end
            end
        end

        // precedence, D before W and a clear A hiding the rest
        write_csr(CSR_STATUS, 8'h00);
        write_csr(CSR_PRIVILEGE, 8'(PRIV_SUPERVISOR));
        fill_entry(20'h61000, 20'h00111, 8'h43);
        fill_entry(20'h61001, 20'h00222, 8'hc3);
        fill_entry(20'h61002, 20'h00333, 8'h1b);
        request_and_check(CMD_STORE, 32'h6100_0010, 1'b1, 20'h00111, 8'h43);
        request_and_check(CMD_STORE, 32'h6100_1020, 1'b1, 20'h00222, 8'hc3);
        request_and_check(CMD_EXECUTE, 32'h6100_2030, 1'b1, 20'h00333, 8'h1b);
        request_and_check(CMD_STORE, 32'h6100_2040, 1'b1, 20'h00333, 8'h1b);

        // back-to-back requests
        flush_tlb();
        fill_entry(20'h60000, 20'h11111, 8'hcf);
        fill_entry(20'h60001, 20'h22222, 8'h43);
        fill_entry(20'h60002, 20'h33333, 8'h0b);
        set_stream(0, CMD_LOAD, 32'h6000_0abc, 1'b1, 20'h11111, 8'hcf);
        set_stream(1, CMD_STORE, 32'h6000_1004, 1'b1, 20'h22222, 8'h43);
        set_stream(2, CMD_EXECUTE, 32'h6000_2ff0, 1'b1, 20'h33333, 8'h0b);
        set_stream(3, CMD_LOAD, 32'h7ffff_000, 1'b0, '0, '0);
        set_stream(4, CMD_STORE, 32'h6000_0010, 1'b1, 20'h11111, 8'hcf);
        for (i = 0; i <= 5; i++) begin
            @(negedge clk);
            if (i > 0) begin
                assert (resp_valid) else abort_run("no response in the cycle after a request");
                compare_response(s_cmd[i-1], s_vaddr[i-1], s_hit[i-1], s_ppn[i-1], s_tag[i-1]);
            end
            if (i < 5) begin
                req_valid = 1'b1;
                req_cmd = s_cmd[i];
                req_vaddr = s_vaddr[i];
            end else begin
                req_valid = 1'b0;
            end
        end

        // a privilege write applies to the very next request
        request_and_check(CMD_LOAD, 32'h6000_0100, 1'b1, 20'h11111, 8'hcf);
        write_csr(CSR_PRIVILEGE, 8'(PRIV_MACHINE));
        request_and_check(CMD_LOAD, 32'h6000_0100, 1'b1, 20'h11111, 8'hcf);

        repeat (2) @(negedge clk);
        if (u_dut.u_assertions.any_failed) begin
            abort_run("a bound assertion failed near the end of the run");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

// File: vlog.f
design/corevx_cache_pkg.sv
design/corevx_cache_csr.sv
design/corevx_cache_tlb.sv
design/corevx_cache_pagefault.sv
design/corevx_cache_mmu.sv
test/corevx_cache_mmu_assertions.sv
test/tb_corevx_cache_mmu.sv

// File: Bender.yml
package:
  name: corevx_cache_mmu

sources:
  - files:
      - design/corevx_cache_pkg.sv
      - design/corevx_cache_csr.sv
      - design/corevx_cache_tlb.sv
      - design/corevx_cache_pagefault.sv
      - design/corevx_cache_mmu.sv
  - target: test
    files:
      - test/corevx_cache_mmu_assertions.sv
      - test/tb_corevx_cache_mmu.sv
